// ==== logic/vmul_pkg.sv ====
package vmul_pkg;

	localparam int DATA_WIDTH = 64;

	// 16 data bits plus one extension bit
	localparam int LANE_WIDTH = 17;

	localparam int NUM_UNITS = 4;

	typedef enum logic [1:0] {
		E8,
		E16,
		E32,
		E_RSVD
	} sew_e;

	typedef enum logic [1:0] {
		OP_MUL,
		OP_MULH,
		OP_MULHSU,
		OP_MULHU
	} mul_op_e;

	// operand word seen by element width
	typedef union packed {
		logic [7:0][7:0] b;
		logic [3:0][15:0] h;
		logic [1:0][31:0] w;
	} vec_word_u;

	// inputs of one 32-bit multiplier unit
	typedef struct packed {
		logic signed [LANE_WIDTH-1:0] a0;
		logic signed [LANE_WIDTH-1:0] a1;
		logic signed [LANE_WIDTH-1:0] b0;
		logic signed [LANE_WIDTH-1:0] b1;
	} unit_operands_t;

	typedef struct packed {
		logic signed [2*LANE_WIDTH-1:0] p0;
		logic signed [2*LANE_WIDTH-1:0] p1;
		logic signed [2*LANE_WIDTH+31:0] full;
	} unit_products_t;

	typedef struct packed {
		sew_e sew;
		logic high;
	} result_ctrl_t;

endpackage

// ==== logic/vmul_operand_select.sv ====
`timescale 1ns/1ps

module vmul_operand_select import vmul_pkg::*; (
	input logic clk,
	input logic rst,
	input vec_word_u vec0,
	input vec_word_u vec1,
	input sew_e sew,
	input mul_op_e op,
	output unit_operands_t [NUM_UNITS-1:0] operands
);

	logic sign_a;
	logic sign_b;
	unit_operands_t [NUM_UNITS-1:0] operands_d;

	function automatic logic signed [LANE_WIDTH-1:0] ext_byte(
		input logic [7:0] v,
		input logic sgn
	);
		return {{(LANE_WIDTH-8){sgn & v[7]}}, v};
	endfunction

	function automatic logic signed [LANE_WIDTH-1:0] ext_half(
		input logic [15:0] v,
		input logic sgn
	);
		return {{(LANE_WIDTH-16){sgn & v[15]}}, v};
	endfunction

	// vec0 is unsigned only for mulhu, vec1 signed for mul and mulh
	assign sign_a = (op != OP_MULHU);
	assign sign_b = (op == OP_MUL) || (op == OP_MULH);

	always_comb begin
		operands_d = '0;
		case (sew)
			E8: begin
				// even byte on a0/b0, odd byte on a1/b1
				for (int u = 0; u < NUM_UNITS; u++) begin
					operands_d[u].a0 = ext_byte(vec0.b[2*u], sign_a);
					operands_d[u].a1 = ext_byte(vec0.b[2*u+1], sign_a);
					operands_d[u].b0 = ext_byte(vec1.b[2*u], sign_b);
					operands_d[u].b1 = ext_byte(vec1.b[2*u+1], sign_b);
				end
			end
			E16: begin
				// four halfwords fill units 0 and 1
				for (int u = 0; u < DATA_WIDTH/32; u++) begin
					operands_d[u].a0 = ext_half(vec0.h[2*u], sign_a);
					operands_d[u].a1 = ext_half(vec0.h[2*u+1], sign_a);
					operands_d[u].b0 = ext_half(vec1.h[2*u], sign_b);
					operands_d[u].b1 = ext_half(vec1.h[2*u+1], sign_b);
				end
			end
			E32: begin
				// upper halfword carries the sign, lower halfword is plain magnitude
				for (int j = 0; j < DATA_WIDTH/32; j++) begin
					operands_d[j].a1 = ext_half(vec0.w[j][31:16], sign_a);
					operands_d[j].a0 = {1'b0, vec0.w[j][15:0]};
					operands_d[j].b1 = ext_half(vec1.w[j][31:16], sign_b);
					operands_d[j].b0 = {1'b0, vec1.w[j][15:0]};
				end
			end
			default: begin
				operands_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			operands <= '0;
		end else begin
			operands <= operands_d;
		end
	end

endmodule

// ==== logic/vmul_mult32.sv ====
`timescale 1ns/1ps

module vmul_mult32 import vmul_pkg::*; (
	input logic clk,
	input logic rst,
	input unit_operands_t operands,
	output unit_products_t products
);

	localparam int PROD_W = 2 * LANE_WIDTH;
	localparam int FULL_W = PROD_W + 32;

	logic signed [PROD_W-1:0] x00;
	logic signed [PROD_W-1:0] x01;
	logic signed [PROD_W-1:0] x10;
	logic signed [PROD_W-1:0] x11;
	logic signed [FULL_W-1:0] full_sum;

	// stage one, cross products of the halfword inputs
	always_ff @(posedge clk) begin
		if (rst) begin
			x00 <= '0;
			x01 <= '0;
			x10 <= '0;
			x11 <= '0;
		end else begin
			x00 <= $signed(operands.a0) * $signed(operands.b0);
			x01 <= $signed(operands.a0) * $signed(operands.b1);
			x10 <= $signed(operands.a1) * $signed(operands.b0);
			x11 <= $signed(operands.a1) * $signed(operands.b1);
		end
	end

	// a = a1*2^16 + a0, same for b
	assign full_sum = (FULL_W'(x11) <<< 32)
		+ ((FULL_W'(x10) + FULL_W'(x01)) <<< 16)
		+ FULL_W'(x00);

	// stage two
	always_ff @(posedge clk) begin
		if (rst) begin
			products <= '0;
		end else begin
			products.p0 <= x00;
			products.p1 <= x11;
			products.full <= full_sum;
		end
	end

endmodule

// ==== logic/vmul_ctrl_pipe.sv ====
`timescale 1ns/1ps

module vmul_ctrl_pipe import vmul_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic [ADDR_WIDTH-1:0] addr,
	input sew_e sew,
	input mul_op_e op,
	output logic valid_out,
	output logic [ADDR_WIDTH-1:0] addr_out,
	output result_ctrl_t ctrl
);

	// operand select plus both multiplier stages
	localparam int DEPTH = 3;

	logic [DEPTH-1:0] valid_q;
	logic [DEPTH-1:0][ADDR_WIDTH-1:0] addr_q;
	result_ctrl_t [DEPTH-1:0] ctrl_q;
	result_ctrl_t ctrl_in;

	always_comb begin
		ctrl_in.sew = sew;
		// reserved width always takes the low path
		ctrl_in.high = (op != OP_MUL) && (sew != E_RSVD);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[DEPTH-2:0], valid};
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= {addr_q[DEPTH-2:0], addr};
		ctrl_q <= {ctrl_q[DEPTH-2:0], ctrl_in};
	end

	assign valid_out = valid_q[DEPTH-1];
	assign addr_out = addr_q[DEPTH-1];
	assign ctrl = ctrl_q[DEPTH-1];

	// request fields known whenever valid
	a_req_known: assert property (
		@(posedge clk) disable iff (rst)
		valid |-> !$isunknown({addr, sew, op})
	);

endmodule

// ==== logic/vmul_result_select.sv ====
`timescale 1ns/1ps

module vmul_result_select import vmul_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic [ADDR_WIDTH-1:0] addr,
	input result_ctrl_t ctrl,
	input unit_products_t [NUM_UNITS-1:0] products,
	output logic out_valid,
	output logic [ADDR_WIDTH-1:0] out_addr,
	output vec_word_u out_vec
);

	vec_word_u res;

	always_comb begin
		res = '0;
		case (ctrl.sew)
			E8: begin
				for (int u = 0; u < NUM_UNITS; u++) begin
					res.b[2*u] = ctrl.high ? products[u].p0[15:8] : products[u].p0[7:0];
					res.b[2*u+1] = ctrl.high ? products[u].p1[15:8] : products[u].p1[7:0];
				end
			end
			E16: begin
				for (int u = 0; u < DATA_WIDTH/32; u++) begin
					res.h[2*u] = ctrl.high ? products[u].p0[31:16] : products[u].p0[15:0];
					res.h[2*u+1] = ctrl.high ? products[u].p1[31:16] : products[u].p1[15:0];
				end
			end
			E32: begin
				// units 0 and 1 hold the word products
				for (int j = 0; j < DATA_WIDTH/32; j++) begin
					res.w[j] = ctrl.high ? products[j].full[63:32] : products[j].full[31:0];
				end
			end
			default: begin
				res = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_vec <= '0;
		end else begin
			out_valid <= valid;
			// idle cycles drive zero
			out_vec <= valid ? res : '0;
		end
	end

	always_ff @(posedge clk) begin
		out_addr <= addr;
	end

	// units 2 and 3 stay idle unless the lanes are bytes
	a_idle_units: assert property (
		@(posedge clk) disable iff (rst)
		valid && (ctrl.sew != E8) |-> (products[2] == '0) && (products[3] == '0)
	);

endmodule

// ==== logic/vmul_top.sv ====
`timescale 1ns/1ps

module vmul_top import vmul_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input vec_word_u in_vec0,
	input vec_word_u in_vec1,
	input sew_e in_sew,
	input mul_op_e in_op,
	input logic [ADDR_WIDTH-1:0] in_addr,
	output logic out_valid,
	output vec_word_u out_vec,
	output logic [ADDR_WIDTH-1:0] out_addr
);

	unit_operands_t [NUM_UNITS-1:0] operands;
	unit_products_t [NUM_UNITS-1:0] products;

	logic pipe_valid;
	logic [ADDR_WIDTH-1:0] pipe_addr;
	result_ctrl_t pipe_ctrl;

	// 1 cycle
	vmul_operand_select u_operand_select (
		.clk      (clk),
		.rst      (rst),
		.vec0     (in_vec0),
		.vec1     (in_vec1),
		.sew      (in_sew),
		.op       (in_op),
		.operands (operands)
	);

	// 2 cycles per unit
	for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
		vmul_mult32 u_mult32 (
			.clk      (clk),
			.rst      (rst),
			.operands (operands[u]),
			.products (products[u])
		);
	end

	// follows the 3 stages above
	vmul_ctrl_pipe #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_ctrl_pipe (
		.clk       (clk),
		.rst       (rst),
		.valid     (in_valid),
		.addr      (in_addr),
		.sew       (in_sew),
		.op        (in_op),
		.valid_out (pipe_valid),
		.addr_out  (pipe_addr),
		.ctrl      (pipe_ctrl)
	);

	// 1 cycle
	vmul_result_select #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_result_select (
		.clk       (clk),
		.rst       (rst),
		.valid     (pipe_valid),
		.addr      (pipe_addr),
		.ctrl      (pipe_ctrl),
		.products  (products),
		.out_valid (out_valid),
		.out_addr  (out_addr),
		.out_vec   (out_vec)
	);

endmodule

// ==== include/vmul_tb_model.svh ====
`ifndef VMUL_TB_MODEL_SVH
`define VMUL_TB_MODEL_SVH

// one lane, operands in the low ew bits
function automatic logic [31:0] model_lane(
	input logic [31:0] a,
	input logic [31:0] b,
	input int ew,
	input mul_op_e op
);
	logic sa;
	logic sb;
	logic signed [32:0] ax;
	logic signed [32:0] bx;
	logic signed [65:0] prod;
	logic [65:0] shifted;
	logic [65:0] mask;
	sa = (op != OP_MULHU);
	sb = (op == OP_MUL) || (op == OP_MULH);
	for (int k = 0; k < 33; k++) begin
		ax[k] = (k < ew) ? a[k] : (sa & a[ew-1]);
		bx[k] = (k < ew) ? b[k] : (sb & b[ew-1]);
	end
	prod = ax * bx;
	shifted = (op == OP_MUL) ? prod : (prod >> ew);
	mask = (66'd1 << ew) - 66'd1;
	return shifted[31:0] & mask[31:0];
endfunction

// full result word for one request
function automatic vec_word_u model_word(
	input vec_word_u a,
	input vec_word_u b,
	input sew_e sew,
	input mul_op_e op
);
	vec_word_u r;
	logic [31:0] lane;
	r = '0;
	case (sew)
		E8: begin
			for (int i = 0; i < 8; i++) begin
				lane = model_lane({24'd0, a.b[i]}, {24'd0, b.b[i]}, 8, op);
				r.b[i] = lane[7:0];
			end
		end
		E16: begin
			for (int i = 0; i < 4; i++) begin
				lane = model_lane({16'd0, a.h[i]}, {16'd0, b.h[i]}, 16, op);
				r.h[i] = lane[15:0];
			end
		end
		E32: begin
			for (int i = 0; i < 2; i++) begin
				r.w[i] = model_lane(a.w[i], b.w[i], 32, op);
			end
		end
		default: begin
			r = '0;
		end
	endcase
	return r;
endfunction

`endif

// ==== verif/vmul_tb.sv ====
`timescale 1ns/1ps

module vmul_tb import vmul_pkg::*; ();

	localparam int ADDR_WIDTH = 32;

	typedef struct packed {
		vec_word_u vec;
		logic [ADDR_WIDTH-1:0] addr;
		logic [31:0] due;
	} expect_t;

	logic clk;
	logic rst;
	logic in_valid;
	vec_word_u in_vec0;
	vec_word_u in_vec1;
	sew_e in_sew;
	mul_op_e in_op;
	logic [ADDR_WIDTH-1:0] in_addr;
	logic out_valid;
	vec_word_u out_vec;
	logic [ADDR_WIDTH-1:0] out_addr;

	expect_t pending[$];
	logic [31:0] cycle;
	int errors;
	int tests_run;
	int tests_failed;
	int valid_seen;
	string cur_test;

	`include "vmul_tb_model.svh"

	vmul_top #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic vec_word_u random_word();
		return {$urandom, $urandom};
	endfunction

	// lanes drawn from min, max, -1 and random
	function automatic vec_word_u corner_word(input sew_e sew);
		logic [63:0] w;
		logic [31:0] v;
		int ew;
		w = {$urandom, $urandom};
		ew = (sew == E8) ? 8 : (sew == E16) ? 16 : 32;
		for (int i = 0; i < 64 / ew; i++) begin
			case ($urandom % 4)
				0: v = 32'h1 << (ew - 1);
				1: v = (32'h1 << (ew - 1)) - 1;
				2: v = '1;
				default: v = $urandom;
			endcase
			for (int k = 0; k < ew; k++) begin
				w[i*ew + k] = v[k];
			end
		end
		return w;
	endfunction

	task automatic check_vec(input string name, input vec_word_u exp, input vec_word_u act);
		if (act !== exp) begin
			$display("MISMATCH %s vec expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
			input logic [ADDR_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s addr expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s arrival cycle expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_ordering(input string name, output logic ok);
		ok = (pending.size() != 0);
		if (!ok) begin
			$display("ERROR %s: out_valid rose with no request pending", name);
			errors++;
		end
	endtask

	always @(negedge clk) begin : monitor
		expect_t e;
		logic ok;
		if (rst) begin
			if (out_valid !== 1'b0) begin
				$display("ERROR %s: out_valid not low during reset", cur_test);
				errors++;
			end
		end else if (out_valid === 1'b1) begin
			valid_seen++;
			check_ordering(cur_test, ok);
			if (ok) begin
				e = pending.pop_front();
				check_vec(cur_test, e.vec, out_vec);
				check_addr(cur_test, e.addr, out_addr);
				check_latency(cur_test, e.due, cycle);
			end
		end else if (out_valid !== 1'b0) begin
			$display("ERROR %s: out_valid is unknown", cur_test);
			errors++;
		end
	end

	task automatic send_request(input vec_word_u a, input vec_word_u b, input sew_e sew,
			input mul_op_e op);
		expect_t e;
		in_valid = 1'b1;
		in_vec0 = a;
		in_vec1 = b;
		in_sew = sew;
		in_op = op;
		in_addr = $urandom;
		e.vec = model_word(a, b, sew, op);
		e.addr = in_addr;
		// sampled at the next rising edge, seen four cycles later
		e.due = cycle + 4;
		pending.push_back(e);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		in_valid = 1'b0;
		in_vec0 = random_word();
		in_vec1 = random_word();
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_drain(input string name);
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (pending.size() != 0) begin
			$display("ERROR %s: timeout, %0d results never arrived", name, pending.size());
			errors++;
			pending.delete();
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic run_lane_test(input string name, input sew_e sew, input mul_op_e op);
		int start_errors;
		start_errors = errors;
		cur_test = name;
		for (int n = 0; n < 40; n++) begin
			if (n % 2 == 0) begin
				send_request(corner_word(sew), corner_word(sew), sew, op);
			end else begin
				send_request(random_word(), random_word(), sew, op);
			end
		end
		wait_drain(name);
		report_test(name, start_errors);
	endtask

	initial begin : main
		sew_e sew;
		mul_op_e op;
		int start_errors;
		void'($urandom(76009));
		rst = 1'b1;
		in_valid = 1'b0;
		in_vec0 = '0;
		in_vec1 = '0;
		in_sew = E8;
		in_op = OP_MUL;
		in_addr = '0;
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		valid_seen = 0;
		cur_test = "reset";
		start_errors = errors;
		repeat (4) @(negedge clk);
		// request in the last reset cycle is dropped
		in_valid = 1'b1;
		in_vec0 = random_word();
		in_vec1 = random_word();
		@(negedge clk);
		rst = 1'b0;
		idle_cycles(8);
		if (valid_seen != 0) begin
			$display("ERROR reset: out_valid rose after reset with no request issued");
			errors++;
		end
		report_test("reset", start_errors);

		for (int o = 0; o < 4; o++) begin
			for (int w = 0; w < 3; w++) begin
				op = mul_op_e'(o);
				sew = sew_e'(w);
				run_lane_test($sformatf("%s_%s", op.name(), sew.name()), sew, op);
			end
		end

		cur_test = "rsvd";
		start_errors = errors;
		for (int n = 0; n < 20; n++) begin
			send_request(random_word(), random_word(), E_RSVD, mul_op_e'($urandom % 4));
		end
		wait_drain("rsvd");
		report_test("rsvd", start_errors);

		cur_test = "stream";
		start_errors = errors;
		for (int n = 0; n < 200; n++) begin
			sew = sew_e'($urandom % 4);
			op = mul_op_e'($urandom % 4);
			send_request(random_word(), random_word(), sew, op);
			if ($urandom % 3 == 0) begin
				idle_cycles(1 + $urandom % 4);
			end
		end
		wait_drain("stream");
		report_test("stream", start_errors);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
logic/vmul_pkg.sv
logic/vmul_operand_select.sv
logic/vmul_mult32.sv
logic/vmul_ctrl_pipe.sv
logic/vmul_result_select.sv
logic/vmul_top.sv
verif/vmul_tb.sv

// ==== Bender.yml ====
package:
  name: vmul

sources:
  - files:
      - logic/vmul_pkg.sv
      - logic/vmul_operand_select.sv
      - logic/vmul_mult32.sv
      - logic/vmul_ctrl_pipe.sv
      - logic/vmul_result_select.sv
      - logic/vmul_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/vmul_tb.sv
